/* src/apb_bridge_pkg.sv */
package apb_bridge_pkg;

    // bus widths
    localparam int apb_aw = 32;
    localparam int apb_dw = 32;
    localparam int apb_sw = apb_dw / 8;

    // address map
    localparam logic [apb_aw-1:0] reg_base = 32'h0000_0000;
    localparam logic [apb_aw-1:0] reg_win  = 32'h0000_0100;
    localparam logic [apb_aw-1:0] mem_base = 32'h0000_1000;

    localparam int mem_words = 16;
    localparam int mem_iw    = $clog2(mem_words);
    localparam logic [apb_aw-1:0] mem_win = apb_aw'(mem_words * apb_sw);

    localparam logic [apb_dw-1:0] bridge_id = 32'h4150_4201;

    // toggle edges ignored right after reset
    localparam int ignore_cycles = 8;
    localparam int ignore_cw     = $clog2(ignore_cycles + 1);

    typedef enum logic [1:0] {
        region_reg,
        region_mem,
        region_none
    } apb_region_e;

    typedef enum logic [2:0] {
        reg_id       = 3'd0,
        reg_scratch0 = 3'd1,
        reg_scratch1 = 3'd2,
        reg_scratch2 = 3'd3,
        reg_scratch3 = 3'd4,
        reg_scratch4 = 3'd5,
        reg_secure0  = 3'd6,
        reg_secure1  = 3'd7
    } reg_idx_e;

endpackage

/* src/apb_intf.sv */
`timescale 1ns/1ps

interface apb_intf;
    import apb_bridge_pkg::*;

    logic              psel;
    logic              penable;
    logic [apb_aw-1:0] paddr;
    logic              pwrite;
    logic [apb_sw-1:0] pstrb;
    logic [2:0]        pprot;
    logic [apb_dw-1:0] pwdata;
    logic [apb_dw-1:0] prdata;
    logic              pready;
    logic              pslverr;

    modport master (
        output psel,
        output penable,
        output paddr,
        output pwrite,
        output pstrb,
        output pprot,
        output pwdata,
        input  prdata,
        input  pready,
        input  pslverr
    );

    modport slave (
        input  psel,
        input  penable,
        input  paddr,
        input  pwrite,
        input  pstrb,
        input  pprot,
        input  pwdata,
        output prdata,
        output pready,
        output pslverr
    );

endinterface

/* src/apb_rx.sv */
`timescale 1ns/1ps

module apb_rx (
    input  logic                              rx_clk,
    input  logic                              rx_rstn,

    input  logic                              tx_tog,
    input  logic [apb_bridge_pkg::apb_aw-1:0] tx_mem_addr,
    input  logic                              tx_mem_write,
    input  logic [apb_bridge_pkg::apb_dw-1:0] tx_mem_wdata,
    input  logic [6:0]                        tx_mem_prot,
    input  logic                              tx_mem_secen,
    output logic                              rx_tog,
    output logic [apb_bridge_pkg::apb_dw-1:0] rx_mem_rdata,
    output logic                              rx_mem_slverr,

    apb_intf.master                           m_apb_intf
);
    import apb_bridge_pkg::*;

    logic                 tog_s1;
    logic                 tog_s2;
    logic                 tog_s3;
    logic [ignore_cw-1:0] ignore_cnt;
    logic                 ignore_tog;
    logic                 rec;
    logic                 rec_dly;
    logic                 done;

    logic [apb_aw-1:0]    req_addr;
    logic                 req_write;
    logic [apb_dw-1:0]    req_wdata;
    logic [2:0]           req_prot;
    logic                 req_secen;

    assign ignore_tog = |ignore_cnt;
    assign rec        = (tog_s2 ^ tog_s3) & ~ignore_tog;
    assign done       = m_apb_intf.penable & m_apb_intf.pready;

    // counts down once after reset, then sticks at zero
    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (!rx_rstn) begin
            ignore_cnt <= ignore_cw'(ignore_cycles);
        end else if (ignore_tog) begin
            ignore_cnt <= ignore_cnt - 1'b1;
        end
    end

    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (!rx_rstn) begin
            tog_s1 <= 1'b0;
            tog_s2 <= 1'b0;
            tog_s3 <= 1'b0;
        end else begin
            tog_s1 <= tx_tog;
            tog_s2 <= tog_s1;
            tog_s3 <= tog_s2;
        end
    end

    // fields are stable by the time the edge gets through the synchroniser
    always_ff @(posedge rx_clk) begin
        if (rec) begin
            req_addr  <= tx_mem_addr;
            req_write <= tx_mem_write;
            req_wdata <= tx_mem_wdata;
            req_prot  <= tx_mem_prot[2:0];
            req_secen <= tx_mem_secen;
        end
    end

    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (!rx_rstn) begin
            rec_dly <= 1'b0;
        end else begin
            rec_dly <= rec;
        end
    end

    // setup then access, held while pready is low
    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (!rx_rstn) begin
            m_apb_intf.psel    <= 1'b0;
            m_apb_intf.penable <= 1'b0;
        end else if (rec_dly) begin
            m_apb_intf.psel    <= 1'b1;
        end else if (done) begin
            m_apb_intf.psel    <= 1'b0;
            m_apb_intf.penable <= 1'b0;
        end else if (m_apb_intf.psel) begin
            m_apb_intf.penable <= 1'b1;
        end
    end

    // no secen means bit 1 forced low, i.e. secure
    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (!rx_rstn) begin
            m_apb_intf.paddr  <= '0;
            m_apb_intf.pwrite <= 1'b0;
            m_apb_intf.pstrb  <= '0;
            m_apb_intf.pprot  <= '0;
            m_apb_intf.pwdata <= '0;
        end else if (rec_dly) begin
            m_apb_intf.paddr  <= req_addr;
            m_apb_intf.pwrite <= req_write;
            m_apb_intf.pstrb  <= '1;
            m_apb_intf.pprot  <= req_prot & {1'b1, req_secen, 1'b1};
            m_apb_intf.pwdata <= req_wdata;
        end
    end

    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (!rx_rstn) begin
            rx_tog        <= 1'b0;
            rx_mem_rdata  <= '0;
            rx_mem_slverr <= 1'b0;
        end else if (done) begin
            rx_tog        <= ~rx_tog;
            rx_mem_rdata  <= m_apb_intf.prdata;
            rx_mem_slverr <= m_apb_intf.pslverr;
        end
    end

endmodule

/* src/apb_fabric.sv */
`timescale 1ns/1ps

module apb_fabric (
    input  logic    rx_clk,
    input  logic    rx_rstn,
    apb_intf.slave  m_apb,
    apb_intf.master s_reg,
    apb_intf.master s_mem
);
    import apb_bridge_pkg::*;

    apb_region_e region_d;
    apb_region_e region_q;
    apb_region_e region;

    // unsigned offset compare covers both window bounds
    always_comb begin
        if ((m_apb.paddr - reg_base) < reg_win) begin
            region_d = region_reg;
        end else if ((m_apb.paddr - mem_base) < mem_win) begin
            region_d = region_mem;
        end else begin
            region_d = region_none;
        end
    end

    // latched in setup, held through access
    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (!rx_rstn) begin
            region_q <= region_none;
        end else if (m_apb.psel && !m_apb.penable) begin
            region_q <= region_d;
        end
    end

    assign region = m_apb.penable ? region_q : region_d;

    assign s_reg.psel    = m_apb.psel && (region == region_reg);
    assign s_reg.penable = m_apb.penable;
    assign s_reg.paddr   = m_apb.paddr;
    assign s_reg.pwrite  = m_apb.pwrite;
    assign s_reg.pstrb   = m_apb.pstrb;
    assign s_reg.pprot   = m_apb.pprot;
    assign s_reg.pwdata  = m_apb.pwdata;

    assign s_mem.psel    = m_apb.psel && (region == region_mem);
    assign s_mem.penable = m_apb.penable;
    assign s_mem.paddr   = m_apb.paddr;
    assign s_mem.pwrite  = m_apb.pwrite;
    assign s_mem.pstrb   = m_apb.pstrb;
    assign s_mem.pprot   = m_apb.pprot;
    assign s_mem.pwdata  = m_apb.pwdata;

    always_comb begin
        case (region)
            region_reg: begin
                m_apb.pready  = s_reg.pready;
                m_apb.prdata  = s_reg.prdata;
                m_apb.pslverr = s_reg.pslverr;
            end
            region_mem: begin
                m_apb.pready  = s_mem.pready;
                m_apb.prdata  = s_mem.prdata;
                m_apb.pslverr = s_mem.pslverr;
            end
            default: begin
                // default responder for unmapped space
                m_apb.pready  = 1'b1;
                m_apb.prdata  = '0;
                m_apb.pslverr = 1'b1;
            end
        endcase
    end

endmodule

/* src/apb_reg_bank.sv */
`timescale 1ns/1ps

module apb_reg_bank (
    input  logic   rx_clk,
    input  logic   rx_rstn,
    apb_intf.slave apb
);
    import apb_bridge_pkg::*;

    // reg_id is a constant, no storage
    logic [apb_dw-1:0] regs [reg_scratch0:reg_secure1];

    reg_idx_e idx;
    logic     access;
    logic     is_secure;
    logic     ro_write;
    logic     deny;
    logic     wr_en;

    assign idx       = reg_idx_e'(apb.paddr[4:2]);
    assign access    = apb.psel && apb.penable;
    assign is_secure = (idx == reg_secure0) || (idx == reg_secure1);
    assign ro_write  = (idx == reg_id) && apb.pwrite;

    // pprot[1] high means non-secure access
    assign deny  = ro_write || (is_secure && apb.pprot[1]);
    assign wr_en = access && apb.pwrite && !deny;

    assign apb.pready  = 1'b1;
    assign apb.pslverr = apb.psel && deny;

    always_comb begin
        if (idx == reg_id) begin
            apb.prdata = bridge_id;
        end else if (deny) begin
            apb.prdata = '0;
        end else begin
            apb.prdata = regs[idx];
        end
    end

    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (!rx_rstn) begin
            for (int i = reg_scratch0; i <= reg_secure1; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[idx] <= apb.pwdata;
        end
    end

endmodule

/* src/apb_sram.sv */
`timescale 1ns/1ps

module apb_sram (
    input  logic   rx_clk,
    input  logic   rx_rstn,
    apb_intf.slave apb
);
    import apb_bridge_pkg::*;

    logic [apb_dw-1:0] mem [mem_words];
    logic [mem_iw-1:0] idx;
    logic              access;
    logic              wait_done;

    assign idx    = apb.paddr[mem_iw+1:2];
    assign access = apb.psel && apb.penable;

    // low in first access cycle, high in the second
    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (!rx_rstn) begin
            wait_done <= 1'b0;
        end else begin
            wait_done <= access && !wait_done;
        end
    end

    assign apb.pready  = wait_done;
    assign apb.pslverr = 1'b0;
    assign apb.prdata  = mem[idx];

    // write lands on the completing edge
    always_ff @(posedge rx_clk) begin
        if (access && wait_done && apb.pwrite) begin
            mem[idx] <= apb.pwdata;
        end
    end

endmodule

/* src/apb_bridge_top.sv */
`timescale 1ns/1ps

module apb_bridge_top (
    input  logic                              rx_clk,
    input  logic                              rx_rstn,

    input  logic                              tx_tog,
    input  logic [apb_bridge_pkg::apb_aw-1:0] tx_mem_addr,
    input  logic                              tx_mem_write,
    input  logic [apb_bridge_pkg::apb_dw-1:0] tx_mem_wdata,
    input  logic [6:0]                        tx_mem_prot,
    input  logic                              tx_mem_secen,
    output logic                              rx_tog,
    output logic [apb_bridge_pkg::apb_dw-1:0] rx_mem_rdata,
    output logic                              rx_mem_slverr
);

    apb_intf m_apb ();
    apb_intf s_reg ();
    apb_intf s_mem ();

    apb_rx u_apb_rx (
        .rx_clk        (rx_clk),
        .rx_rstn       (rx_rstn),
        .tx_tog        (tx_tog),
        .tx_mem_addr   (tx_mem_addr),
        .tx_mem_write  (tx_mem_write),
        .tx_mem_wdata  (tx_mem_wdata),
        .tx_mem_prot   (tx_mem_prot),
        .tx_mem_secen  (tx_mem_secen),
        .rx_tog        (rx_tog),
        .rx_mem_rdata  (rx_mem_rdata),
        .rx_mem_slverr (rx_mem_slverr),
        .m_apb_intf    (m_apb.master)
    );

    apb_fabric u_apb_fabric (
        .rx_clk  (rx_clk),
        .rx_rstn (rx_rstn),
        .m_apb   (m_apb.slave),
        .s_reg   (s_reg.master),
        .s_mem   (s_mem.master)
    );

    apb_reg_bank u_apb_reg_bank (
        .rx_clk  (rx_clk),
        .rx_rstn (rx_rstn),
        .apb     (s_reg.slave)
    );

    apb_sram u_apb_sram (
        .rx_clk  (rx_clk),
        .rx_rstn (rx_rstn),
        .apb     (s_mem.slave)
    );

endmodule

/* verification/apb_bridge_chk.sv */
`timescale 1ns/1ps

module apb_bridge_chk (
    input logic                              rx_clk,
    input logic                              rx_rstn,
    input logic                              psel,
    input logic                              penable,
    input logic                              pready,
    input logic [apb_bridge_pkg::apb_aw-1:0] paddr,
    input logic                              pwrite,
    input logic [apb_bridge_pkg::apb_dw-1:0] pwdata,
    input logic                              rx_tog
);
    import apb_bridge_pkg::*;

    int unsigned since_rst;

    // saturating count of cycles since reset release
    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (!rx_rstn) begin
            since_rst <= 0;
        end else if (since_rst < ignore_cycles) begin
            since_rst <= since_rst + 1;
        end
    end

    assert property (@(posedge rx_clk) disable iff (!rx_rstn)
        penable |-> psel)
        else $error("penable high without psel");

    // held through setup and any wait states
    assert property (@(posedge rx_clk) disable iff (!rx_rstn)
        (psel && !(penable && pready)) |=> ($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else $error("paddr, pwrite or pwdata changed during a transfer");

    assert property (@(posedge rx_clk) disable iff (!rx_rstn)
        (rx_tog != $past(rx_tog)) |-> $past(penable && pready))
        else $error("rx_tog flipped without a completed transfer");

    assert property (@(posedge rx_clk) disable iff (!rx_rstn)
        (since_rst < ignore_cycles) |-> !psel)
        else $error("psel raised inside the ignore window");

endmodule

bind apb_rx apb_bridge_chk u_chk (
    .rx_clk  (rx_clk),
    .rx_rstn (rx_rstn),
    .psel    (m_apb_intf.psel),
    .penable (m_apb_intf.penable),
    .pready  (m_apb_intf.pready),
    .paddr   (m_apb_intf.paddr),
    .pwrite  (m_apb_intf.pwrite),
    .pwdata  (m_apb_intf.pwdata),
    .rx_tog  (rx_tog)
);

/* verification/tb_apb_bridge.sv */
`timescale 1ns/1ps

module tb_apb_bridge;
    import apb_bridge_pkg::*;

    // roughly 380 cycles of traffic, the rest is margin
    localparam int max_cycles = 2000;

    logic              rx_clk = 1'b0;
    logic              rx_rstn;
    logic              tx_tog;
    logic [apb_aw-1:0] tx_mem_addr;
    logic              tx_mem_write;
    logic [apb_dw-1:0] tx_mem_wdata;
    logic [6:0]        tx_mem_prot;
    logic              tx_mem_secen;
    logic              rx_tog;
    logic [apb_dw-1:0] rx_mem_rdata;
    logic              rx_mem_slverr;

    int                pass_cnt = 0;
    int                fail_cnt = 0;
    int                test_errs = 0;
    int                cycles = 0;
    logic [15:0]       lfsr_state = 16'd40196;
    int                resp_edges;
    logic [apb_dw-1:0] resp_data;
    logic              resp_err;
    logic [apb_dw-1:0] scratch_model [1:5];
    logic [apb_dw-1:0] mem_model [mem_words];

    apb_bridge_top uut (
        .rx_clk        (rx_clk),
        .rx_rstn       (rx_rstn),
        .tx_tog        (tx_tog),
        .tx_mem_addr   (tx_mem_addr),
        .tx_mem_write  (tx_mem_write),
        .tx_mem_wdata  (tx_mem_wdata),
        .tx_mem_prot   (tx_mem_prot),
        .tx_mem_secen  (tx_mem_secen),
        .rx_tog        (rx_tog),
        .rx_mem_rdata  (rx_mem_rdata),
        .rx_mem_slverr (rx_mem_slverr)
    );

    always #5 rx_clk = ~rx_clk;

    always @(posedge rx_clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, a request never completed", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[15]};
        end
        return v;
    endfunction

    function automatic logic [apb_aw-1:0] reg_addr(input reg_idx_e r);
        return reg_base + (apb_aw'(r) << 2);
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail %s: got %h expected %h", sig, got, exp);
        test_errs++;
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("%s ok", name);
        end else begin
            fail_cnt++;
            $display("%s %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // called 1 ns after a rising edge; returns at the same phase
    task automatic do_request(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                              input logic [6:0] prot, input logic secen);
        tx_mem_addr  = addr;
        tx_mem_write = wr;
        tx_mem_wdata = wdata;
        tx_mem_prot  = prot;
        tx_mem_secen = secen;
        tx_tog       = ~tx_tog;
        // edge k takes the flip in, latency counts from there
        @(posedge rx_clk);
        #1;
        resp_edges   = 0;
        while (rx_tog !== tx_tog) begin
            @(posedge rx_clk);
            resp_edges++;
            #1;
        end
        resp_data = rx_mem_rdata;
        resp_err  = rx_mem_slverr;
    endtask

    task automatic check_resp(input int exp_edges, input logic [31:0] exp_data,
                              input logic exp_err, input logic data_valid);
        if (resp_edges != exp_edges) begin
            $display("request completed after %0d edges instead of %0d",
                     resp_edges, exp_edges);
            test_errs++;
        end
        if (resp_err !== exp_err) report_mismatch("rx_mem_slverr", resp_err, exp_err);
        if (data_valid && resp_data !== exp_data) begin
            report_mismatch("rx_mem_rdata", resp_data, exp_data);
        end
    endtask

    task automatic test_reset_ignore();
        if (rx_tog !== 1'b0) report_mismatch("rx_tog", rx_tog, 0);
        if (rx_mem_slverr !== 1'b0) report_mismatch("rx_mem_slverr", rx_mem_slverr, 0);
        if (rx_mem_rdata !== '0) report_mismatch("rx_mem_rdata", rx_mem_rdata, 0);
        // two flips, both inside the ignore window
        @(posedge rx_clk);
        #1 tx_tog = 1'b1;
        repeat (2) @(posedge rx_clk);
        #1 tx_tog = 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(posedge rx_clk);
            #1;
            if (rx_tog !== 1'b0) report_mismatch("rx_tog", rx_tog, 0);
        end
        finish_test("reset");
    endtask

    task automatic test_scratch();
        for (int i = 1; i <= 5; i++) begin
            scratch_model[i] = rand_word();
            do_request(reg_addr(reg_idx_e'(i)), 1'b1, scratch_model[i], 7'h00, 1'b0);
            check_resp(5, '0, 1'b0, 1'b0);
        end
        for (int i = 1; i <= 5; i++) begin
            do_request(reg_addr(reg_idx_e'(i)), 1'b0, '0, 7'h00, 1'b0);
            check_resp(5, scratch_model[i], 1'b0, 1'b1);
        end
        finish_test("scratch");
    endtask

    task automatic test_id();
        do_request(reg_addr(reg_id), 1'b0, '0, 7'h00, 1'b0);
        check_resp(5, bridge_id, 1'b0, 1'b1);
        do_request(reg_addr(reg_id), 1'b1, rand_word(), 7'h00, 1'b0);
        check_resp(5, '0, 1'b1, 1'b0);
        do_request(reg_addr(reg_id), 1'b0, '0, 7'h00, 1'b0);
        check_resp(5, bridge_id, 1'b0, 1'b1);
        finish_test("id");
    endtask

    task automatic test_secure();
        logic [31:0] kept;
        kept = rand_word();
        // prot bit 1 set but secen low, so still a secure access
        do_request(reg_addr(reg_secure0), 1'b1, kept, 7'h02, 1'b0);
        check_resp(5, '0, 1'b0, 1'b0);
        do_request(reg_addr(reg_secure0), 1'b0, '0, 7'h02, 1'b0);
        check_resp(5, kept, 1'b0, 1'b1);
        do_request(reg_addr(reg_secure0), 1'b0, '0, 7'h02, 1'b1);
        check_resp(5, '0, 1'b1, 1'b1);
        do_request(reg_addr(reg_secure0), 1'b1, rand_word(), 7'h02, 1'b1);
        check_resp(5, '0, 1'b1, 1'b0);
        do_request(reg_addr(reg_secure0), 1'b0, '0, 7'h00, 1'b0);
        check_resp(5, kept, 1'b0, 1'b1);
        finish_test("secure");
    endtask

    task automatic test_sram();
        for (int i = 0; i < mem_words; i++) begin
            mem_model[i] = rand_word();
            do_request(mem_base + 32'(i * 4), 1'b1, mem_model[i], 7'h00, 1'b0);
            check_resp(6, '0, 1'b0, 1'b0);
        end
        for (int i = mem_words - 1; i >= 0; i--) begin
            do_request(mem_base + 32'(i * 4), 1'b0, '0, 7'h00, 1'b0);
            check_resp(6, mem_model[i], 1'b0, 1'b1);
        end
        finish_test("sram");
    endtask

    task automatic test_unmapped();
        do_request(32'h0000_2000, 1'b0, '0, 7'h00, 1'b0);
        check_resp(5, '0, 1'b1, 1'b1);
        do_request(32'h0000_2000, 1'b1, rand_word(), 7'h00, 1'b0);
        check_resp(5, '0, 1'b1, 1'b0);
        do_request(reg_addr(reg_id), 1'b0, '0, 7'h00, 1'b0);
        check_resp(5, bridge_id, 1'b0, 1'b1);
        finish_test("unmapped");
    endtask

    initial begin
        rx_rstn      = 1'b0;
        tx_tog       = 1'b0;
        tx_mem_addr  = '0;
        tx_mem_write = 1'b0;
        tx_mem_wdata = '0;
        tx_mem_prot  = '0;
        tx_mem_secen = 1'b0;
        repeat (3) @(posedge rx_clk);
        #1 rx_rstn = 1'b1;

        test_reset_ignore();
        test_scratch();
        test_id();
        test_secure();
        test_sram();
        test_unmapped();

        $display("passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* build.f */
src/apb_bridge_pkg.sv
src/apb_intf.sv
src/apb_rx.sv
src/apb_fabric.sv
src/apb_reg_bank.sv
src/apb_sram.sv
src/apb_bridge_top.sv
verification/apb_bridge_chk.sv
verification/tb_apb_bridge.sv
